// File: sim.f
src/cpu_pkg.sv
src/fetch.sv
src/regfile.sv
src/decode.sv
src/execute.sv
src/memacc.sv
src/cpu.sv
dv/tb_clk.sv
dv/cpu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f sim.f -o cpu_tb_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -qx "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: dv/cpu_tb.sv
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  localparam int NSTORES = 11;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int DRAIN_CYCLES = 20;
  localparam logic [31:0] NOP = 32'h0000_0013;
  localparam logic [31:0] MARKER_ADDR = 32'h0000_03fc;

  // Expected stores in program order for the program below
  localparam logic [31:0] EXP_ADDR [NSTORES] = '{
    32'h114, 32'h110, 32'h100, 32'h104, 32'h108, 32'h10c,
    32'h118, 32'h11c, 32'h128, 32'h12c, 32'h3fc
  };
  localparam logic [31:0] EXP_DATA [NSTORES] = '{
    32'h0000_001d, 32'h0400_001d, 32'h0000_0011, 32'h0000_03a0,
    32'h8000_03a0, 32'h0000_0001, 32'h1234_8085, 32'h0000_03a0,
    32'h0000_001d, 32'h0000_0000, 32'h0000_0005
  };

  logic        clk;
  logic        rstn;
  imem_req_t   imem_req;
  logic        imem_ready;
  logic [31:0] imem_rdata;
  dmem_req_t   dmem_req;
  logic        dmem_ready;
  logic [31:0] dmem_rdata;

  logic [31:0] rom [64];
  logic [31:0] dmem [256];
  logic [15:0] lfsr;
  int          n_stores;
  int          mismatches;
  int          other_errors;
  logic        marker_seen;

  tb_clk clk0 (.clk_o(clk));

  cpu dut0 (
    .clk         (clk),
    .rstn        (rstn),
    .imem_req_o  (imem_req),
    .imem_ready_i(imem_ready),
    .imem_rdata_i(imem_rdata),
    .dmem_req_o  (dmem_req),
    .dmem_ready_i(dmem_ready),
    .dmem_rdata_i(dmem_rdata)
  );

  function automatic logic [31:0] rtype(input int rd, input int rs1, input int rs2,
                                        input int f3, input int f7);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction

  function automatic logic [31:0] itype(input int op, input int rd, input int f3,
                                        input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
  endfunction

  function automatic logic [31:0] stype(input int rs2, input int rs1, input int imm);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2,
                                        input int imm);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'h63};
  endfunction

  function automatic logic [31:0] utype(input int rd, input int imm);
    return {20'(imm), 5'(rd), 7'h37};
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // Ready is low only when both drawn bits are zero
  task automatic step_ready(output logic ready);
    logic b0;
    logic b1;
    lfsr = lfsr_next(lfsr);
    b0 = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1 = lfsr[0];
    ready = b0 | b1;
  endtask

  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      rom[i] = NOP;
    end
    // Dependent ALU chain
    rom[0]  = itype('h13, 1, 0, 0, 5);
    rom[1]  = itype('h13, 2, 0, 1, 7);
    rom[2]  = rtype(3, 1, 2, 0, 'h00);
    rom[3]  = rtype(4, 3, 1, 0, 'h20);
    rom[4]  = rtype(5, 4, 3, 4, 'h00);
    rom[5]  = rtype(6, 5, 1, 1, 'h00);
    rom[6]  = utype(7, 'h80000);
    rom[7]  = rtype(8, 7, 6, 6, 'h00);
    rom[8]  = rtype(9, 8, 1, 2, 'h00);
    rom[9]  = rtype(10, 8, 1, 5, 'h00);
    rom[10] = rtype(11, 10, 5, 7, 'h00);
    rom[11] = stype(11, 0, 'h114);
    rom[12] = stype(10, 0, 'h110);
    rom[13] = stype(3, 0, 'h100);
    rom[14] = stype(6, 0, 'h104);
    rom[15] = stype(8, 0, 'h108);
    rom[16] = stype(9, 0, 'h10c);
    // Load-use pairs
    rom[17] = itype('h03, 12, 2, 0, 'h200);
    rom[18] = rtype(13, 12, 1, 0, 'h00);
    rom[19] = stype(13, 0, 'h118);
    rom[20] = itype('h03, 14, 2, 0, 'h104);
    rom[21] = stype(14, 0, 'h11c);
    // Taken BEQ skips two stores and BNE falls through
    rom[22] = btype(0, 2, 4, 12);
    rom[23] = stype(1, 0, 'h120);
    rom[24] = stype(2, 0, 'h124);
    rom[25] = btype(1, 3, 3, 8);
    rom[26] = stype(5, 0, 'h128);
    // Writes to x0 are dropped
    rom[27] = itype('h13, 0, 0, 0, 99);
    rom[28] = rtype(0, 1, 2, 0, 'h00);
    rom[29] = stype(0, 0, 'h12c);
    rom[30] = stype(1, 0, 'h3fc);
    rom[31] = btype(0, 0, 0, 0);
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    if (n_stores >= NSTORES) begin
      other_errors++;
      $display("Unexpected store after the last one at %0t: address %h data %h",
               $time, addr, data);
    end else begin
      assert (addr == EXP_ADDR[n_stores]) else begin
        mismatches++;
        $display("Mismatch at %0t: dmem_req_o.addr of store %0d expected %h, got %h",
                 $time, n_stores, EXP_ADDR[n_stores], addr);
      end
      assert (data == EXP_DATA[n_stores]) else begin
        mismatches++;
        $display("Mismatch at %0t: dmem_req_o.wdata of store %0d expected %h, got %h",
                 $time, n_stores, EXP_DATA[n_stores], data);
      end
    end
    if (addr == MARKER_ADDR) begin
      marker_seen = 1'b1;
    end
    n_stores++;
  endtask

  assign imem_rdata = (imem_req.addr[31:8] == '0) ? rom[imem_req.addr[7:2]] : NOP;
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(negedge clk) begin
    step_ready(imem_ready);
    step_ready(dmem_ready);
  end

  always @(posedge clk) begin
    if (rstn && dmem_req.valid && dmem_ready) begin
      if (dmem_req.addr[31:10] != '0 || dmem_req.addr[1:0] != 2'b00) begin
        other_errors++;
        $display("Data access outside the memory or unaligned at %0t: address %h",
                 $time, dmem_req.addr);
      end else if (dmem_req.write) begin
        dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        check_store(dmem_req.addr, dmem_req.wdata);
      end
    end
  end

  reset_fetch_a: assert property (@(posedge clk)
    $rose(rstn) |-> imem_req.valid && imem_req.addr == '0)
  else begin
    mismatches++;
    $display("Mismatch at %0t: imem_req_o expected valid 1 addr 00000000, got valid %0b addr %h",
             $time, $sampled(imem_req.valid), $sampled(imem_req.addr));
  end

  reset_data_a: assert property (@(posedge clk)
    (!rstn || $rose(rstn)) |-> !dmem_req.valid)
  else begin
    mismatches++;
    $display("Mismatch at %0t: dmem_req_o.valid expected 0, got %0b",
             $time, $sampled(dmem_req.valid));
  end

  dmem_stable_a: assert property (@(posedge clk) disable iff (!rstn)
    dmem_req.valid && !dmem_ready |=> $stable(dmem_req))
  else begin
    other_errors++;
    $display("dmem_req_o changed while waiting for ready at %0t", $time);
  end

  initial begin
    int cycles;
    rstn = 1'b0;
    imem_ready = 1'b0;
    dmem_ready = 1'b0;
    lfsr = 16'd47;
    n_stores = 0;
    mismatches = 0;
    other_errors = 0;
    marker_seen = 1'b0;
    load_program();
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'h1234_0000 + 32'(i) * 32'h0000_0101;
    end
    repeat (3) begin
      @(negedge clk);
    end
    rstn = 1'b1;
    cycles = 0;
    while (!marker_seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!marker_seen) begin
      other_errors++;
      $display("Timeout: no marker store within %0d cycles after reset", TIMEOUT_CYCLES);
    end
    // Anything stored after the marker is an error
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      @(negedge clk);
    end
    $display("Stores checked: %0d, mismatches: %0d, other failures: %0d",
             n_stores, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk.sv
`default_nettype none

module tb_clk (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: src/cpu.sv
`default_nettype none

module cpu (
  input  logic                     clk,
  input  logic                     rstn,
  output cpu_pkg::imem_req_t       imem_req_o,
  input  logic                     imem_ready_i,
  input  logic [31:0]              imem_rdata_i,
  output cpu_pkg::dmem_req_t       dmem_req_o,
  input  logic                     dmem_ready_i,
  input  logic [cpu_pkg::XLEN-1:0] dmem_rdata_i
);
  import cpu_pkg::*;

  if_id_t                if_id;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  wb_t                   mem_fwd;
  wb_t                   wb;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       branch_target;
  logic                  branch_taken;
  logic                  ex_is_load;
  logic                  mem_stall;
  logic                  load_use_stall;
  logic                  fetch_stall;

  // Front end also holds for a load-use hazard
  assign fetch_stall = mem_stall || load_use_stall;

  fetch fetch0 (
    .clk            (clk),
    .rstn           (rstn),
    .stall_i        (fetch_stall),
    .branch_taken_i (branch_taken),
    .branch_target_i(branch_target),
    .imem_req_o     (imem_req_o),
    .imem_ready_i   (imem_ready_i),
    .imem_rdata_i   (imem_rdata_i),
    .if_id_o        (if_id)
  );

  regfile regfile0 (
    .clk       (clk),
    .rstn      (rstn),
    .rs1_addr_i(rs1_addr),
    .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wb_i      (wb)
  );

  decode decode0 (
    .if_id_i         (if_id),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .ex_is_load_i    (ex_is_load),
    .ex_rd_i         (ex_rd),
    .id_ex_o         (id_ex),
    .load_use_stall_o(load_use_stall)
  );

  execute execute0 (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (mem_stall),
    .load_use_stall_i(load_use_stall),
    .id_ex_i         (id_ex),
    .mem_fwd_i       (mem_fwd),
    .wb_fwd_i        (wb),
    .ex_mem_o        (ex_mem),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .ex_is_load_o    (ex_is_load),
    .ex_rd_o         (ex_rd)
  );

  memacc memacc0 (
    .clk         (clk),
    .rstn        (rstn),
    .ex_mem_i    (ex_mem),
    .dmem_req_o  (dmem_req_o),
    .dmem_ready_i(dmem_ready_i),
    .dmem_rdata_i(dmem_rdata_i),
    .mem_stall_o (mem_stall),
    .mem_fwd_o   (mem_fwd),
    .wb_o        (wb)
  );

endmodule

`default_nettype wire

// File: src/memacc.sv
`default_nettype none

module memacc (
  input  logic                     clk,
  input  logic                     rstn,
  input  cpu_pkg::ex_mem_t         ex_mem_i,
  output cpu_pkg::dmem_req_t       dmem_req_o,
  input  logic                     dmem_ready_i,
  input  logic [cpu_pkg::XLEN-1:0] dmem_rdata_i,
  output logic                     mem_stall_o,
  output cpu_pkg::wb_t             mem_fwd_o,
  output cpu_pkg::wb_t             wb_o
);
  import cpu_pkg::*;

  ex_mem_t               ex_mem_q;
  ex_mem_t               mq;
  logic                  mem_valid_q;
  logic                  wb_we_q;
  logic [REG_ADDR_W-1:0] wb_rd_q;
  logic [XLEN-1:0]       wb_data_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_valid_q <= 1'b0;
    end else if (!mem_stall_o) begin
      mem_valid_q <= ex_mem_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall_o) begin
      ex_mem_q <= ex_mem_i;
    end
  end

  always_comb begin
    mq       = ex_mem_q;
    mq.valid = mem_valid_q;
  end

  assign dmem_req_o = '{valid: mq.valid && (mq.mem_read || mq.mem_write),
                        write: mq.mem_write,
                        addr:  mq.alu_res,
                        wdata: mq.store_data};

  assign mem_stall_o = dmem_req_o.valid && !dmem_ready_i;

  // Load data is not available yet, so loads never forward from here
  assign mem_fwd_o = '{we: mq.valid && mq.reg_write && !mq.mem_read,
                       rd: mq.rd, data: mq.alu_res};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= !mem_stall_o && mq.valid && mq.reg_write && mq.rd != '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall_o) begin
      wb_rd_q   <= mq.rd;
      wb_data_q <= mq.mem_read ? dmem_rdata_i : mq.alu_res;
    end
  end

  assign wb_o = '{we: wb_we_q, rd: wb_rd_q, data: wb_data_q};

  // Data port handshake
  req_stable_a: assert property (@(posedge clk) disable iff (!rstn)
    dmem_req_o.valid && !dmem_ready_i |=> $stable(dmem_req_o));

endmodule

`default_nettype wire

// File: src/execute.sv
`default_nettype none

module execute (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           stall_i,
  input  logic                           load_use_stall_i,
  input  cpu_pkg::id_ex_t                id_ex_i,
  input  cpu_pkg::wb_t                   mem_fwd_i,
  input  cpu_pkg::wb_t                   wb_fwd_i,
  output cpu_pkg::ex_mem_t               ex_mem_o,
  output logic                           branch_taken_o,
  output logic [cpu_pkg::XLEN-1:0]       branch_target_o,
  output logic                           ex_is_load_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd_o
);
  import cpu_pkg::*;

  id_ex_t          id_ex_q;
  id_ex_t          ex;
  logic            ex_valid_q;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] fwd_b;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;

  // Memory stage wins over writeback
  function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] idx,
                                              input logic [XLEN-1:0]       reg_val,
                                              input wb_t                   mem_src,
                                              input wb_t                   wb_src);
    if (idx == '0) return reg_val;
    if (mem_src.we && mem_src.rd == idx) return mem_src.data;
    if (wb_src.we && wb_src.rd == idx) return wb_src.data;
    return reg_val;
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_valid_q <= 1'b0;
    end else if (!stall_i) begin
      ex_valid_q <= id_ex_i.valid && !branch_taken_o && !load_use_stall_i;
    end
  end

  always_ff @(posedge clk) begin
    if (stall_i) begin
      // Writeback drains to a bubble while frozen so the forwarded operands are kept
      id_ex_q.rs1_data <= op_a;
      id_ex_q.rs2_data <= fwd_b;
    end else begin
      id_ex_q <= id_ex_i;
    end
  end

  always_comb begin
    ex       = id_ex_q;
    ex.valid = ex_valid_q;
  end

  assign op_a  = forward(ex.rs1, ex.rs1_data, mem_fwd_i, wb_fwd_i);
  assign fwd_b = forward(ex.rs2, ex.rs2_data, mem_fwd_i, wb_fwd_i);
  assign op_b  = ex.use_imm ? ex.imm : fwd_b;

  always_comb begin
    case (ex.alu_op)
      ALU_ADD:   alu_res = op_a + op_b;
      ALU_SUB:   alu_res = op_a - op_b;
      ALU_AND:   alu_res = op_a & op_b;
      ALU_OR:    alu_res = op_a | op_b;
      ALU_XOR:   alu_res = op_a ^ op_b;
      ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLL:   alu_res = op_a << op_b[4:0];
      ALU_SRL:   alu_res = op_a >> op_b[4:0];
      ALU_PASSB: alu_res = op_b;
      default:   alu_res = op_a + op_b;
    endcase
  end

  assign branch_taken_o  = ex.valid && ex.is_branch && ((op_a == fwd_b) == ex.br_eq);
  assign branch_target_o = ex.pc + ex.imm;
  assign ex_is_load_o    = ex.valid && ex.mem_read;
  assign ex_rd_o         = ex.rd;

  assign ex_mem_o = '{valid: ex.valid, rd: ex.rd, reg_write: ex.reg_write,
                      mem_read: ex.mem_read, mem_write: ex.mem_write,
                      alu_res: alu_res, store_data: fwd_b};

  // A held front end would lose the redirect
  branch_no_bubble_a: assert property (@(posedge clk) disable iff (!rstn)
    branch_taken_o |-> !load_use_stall_i);

endmodule

`default_nettype wire

// File: src/decode.sv
`default_nettype none

module decode (
  input  cpu_pkg::if_id_t                if_id_i,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [cpu_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [cpu_pkg::XLEN-1:0]       rs2_data_i,
  input  logic                           ex_is_load_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd_i,
  output cpu_pkg::id_ex_t                id_ex_o,
  output logic                           load_use_stall_o
);
  import cpu_pkg::*;

  logic [31:0]     instr;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic            funct7_5;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic            legal;
  logic            use_rs1;
  logic            use_rs2;
  id_ex_t          d;

  assign instr    = if_id_i.instr;
  assign opcode   = opcode_e'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign rs1_addr_o = instr[19:15];
  assign rs2_addr_o = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    d          = '0;
    legal      = 1'b1;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    d.pc       = if_id_i.pc;
    d.alu_op   = ALU_ADD;
    d.rs1      = rs1_addr_o;
    d.rs2      = rs2_addr_o;
    d.rs1_data = rs1_data_i;
    d.rs2_data = rs2_data_i;
    d.rd       = instr[11:7];
    case (opcode)
      OP_REG: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        d.reg_write = 1'b1;
        case (funct3)
          3'b000: d.alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
          3'b111: d.alu_op = ALU_AND;
          3'b110: d.alu_op = ALU_OR;
          3'b100: d.alu_op = ALU_XOR;
          3'b010: d.alu_op = ALU_SLT;
          3'b001: d.alu_op = ALU_SLL;
          3'b101: begin
            // SRA is not supported
            d.alu_op = ALU_SRL;
            legal    = !funct7_5;
          end
          default: legal = 1'b0;
        endcase
      end
      OP_IMM: begin
        use_rs1     = 1'b1;
        d.use_imm   = 1'b1;
        d.imm       = imm_i;
        d.reg_write = 1'b1;
        legal       = funct3 == 3'b000;
      end
      OP_LUI: begin
        d.alu_op    = ALU_PASSB;
        d.use_imm   = 1'b1;
        d.imm       = imm_u;
        d.reg_write = 1'b1;
      end
      OP_LOAD: begin
        use_rs1     = 1'b1;
        d.use_imm   = 1'b1;
        d.imm       = imm_i;
        d.reg_write = 1'b1;
        d.mem_read  = 1'b1;
        legal       = funct3 == 3'b010;
      end
      OP_STORE: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        d.use_imm   = 1'b1;
        d.imm       = imm_s;
        d.mem_write = 1'b1;
        legal       = funct3 == 3'b010;
      end
      OP_BRANCH: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        d.imm       = imm_b;
        d.is_branch = 1'b1;
        d.br_eq     = !funct3[0];
        legal       = funct3[2:1] == 2'b00;
      end
      default: legal = 1'b0;
    endcase
    d.valid = if_id_i.valid && legal;
  end

  assign id_ex_o = d;

  // Load result is not ready until it reaches writeback
  assign load_use_stall_o = if_id_i.valid && ex_is_load_i && ex_rd_i != '0 &&
                            ((use_rs1 && rs1_addr_o == ex_rd_i) ||
                             (use_rs2 && rs2_addr_o == ex_rd_i));

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [cpu_pkg::XLEN-1:0]       rs1_data_o,
  output logic [cpu_pkg::XLEN-1:0]       rs2_data_o,
  input  cpu_pkg::wb_t                   wb_i
);
  import cpu_pkg::*;

  logic [XLEN-1:0] regs [32];

  // Write-through so decode sees the value retiring this cycle
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0]       stored,
                                                input wb_t                   wb);
    if (addr == '0) return '0;
    if (wb.we && wb.rd == addr) return wb.data;
    return stored;
  endfunction

  assign rs1_data_o = read_port(rs1_addr_i, regs[rs1_addr_i], wb_i);
  assign rs2_data_o = read_port(rs2_addr_i, regs[rs2_addr_i], wb_i);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.we && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

endmodule

`default_nettype wire

// File: src/fetch.sv
`default_nettype none

module fetch (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     stall_i,
  input  logic                     branch_taken_i,
  input  logic [cpu_pkg::XLEN-1:0] branch_target_i,
  output cpu_pkg::imem_req_t       imem_req_o,
  input  logic                     imem_ready_i,
  input  logic [31:0]              imem_rdata_i,
  output cpu_pkg::if_id_t          if_id_o
);
  import cpu_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            if_valid_q;
  logic [XLEN-1:0] if_pc_q;
  logic [31:0]     if_instr_q;
  logic            fetch_ok;

  assign imem_req_o = '{valid: 1'b1, addr: pc_q};
  assign fetch_ok = imem_req_o.valid && imem_ready_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc_q       <= '0;
      if_valid_q <= 1'b0;
    end else if (!stall_i) begin
      if (branch_taken_i) begin
        // Redirect and drop the word fetched this cycle
        pc_q       <= branch_target_i;
        if_valid_q <= 1'b0;
      end else begin
        if_valid_q <= fetch_ok;
        if (fetch_ok) begin
          pc_q <= pc_q + XLEN'(4);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i && fetch_ok) begin
      if_pc_q    <= pc_q;
      if_instr_q <= imem_rdata_i;
    end
  end

  assign if_id_o = '{valid: if_valid_q, pc: if_pc_q, instr: if_instr_q};

  // Branch targets from execute must keep the pc aligned
  pc_aligned_a: assert property (@(posedge clk) disable iff (!rstn)
    pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // RV32I major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASSB
  } alu_op_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_branch;
    logic                  br_eq;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       store_data;
  } ex_mem_t;

  // Shared by forwarding and the register file write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire
